/* source/delay_stream.sv */
`timescale 1ns/1ps

module delay_stream
    import dot_pkg::*;
#(
    parameter int N = 1
) (
    input  logic  aclk,
    input  logic  aclken,
    input  logic  rst_n,

    input  logic  valid_in,
    input  data_t data_in,
    input  logic  last_in,
    input  user_t user_in,

    output logic  valid_out,
    output data_t data_out,
    output logic  last_out,
    output user_t user_out
);

    logic [N-1:0] valid_q;
    logic [N-1:0] last_q;
    data_t        data_q [N];
    user_t        user_q [N];

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            valid_q <= '0;
            last_q  <= '0;
        end else if (aclken) begin
            valid_q[0] <= valid_in;
            last_q[0]  <= last_in;
            for (int i = 1; i < N; i++) begin
                valid_q[i] <= valid_q[i-1];
                last_q[i]  <= last_q[i-1];
            end
        end
    end

    // payload only, qualified by valid
    always_ff @(posedge aclk) begin
        if (aclken) begin
            data_q[0] <= data_in;
            user_q[0] <= user_in;
            for (int i = 1; i < N; i++) begin
                data_q[i] <= data_q[i-1];
                user_q[i] <= user_q[i-1];
            end
        end
    end

    assign valid_out = valid_q[N-1];
    assign last_out  = last_q[N-1];
    assign data_out  = data_q[N-1];
    assign user_out  = user_q[N-1];

endmodule

/* source/dot_engine.sv */
`timescale 1ns/1ps

module dot_engine
    import dot_pkg::*;
#(
    parameter int MUL_DELAY = 3,
    parameter int ACC_DELAY = 2
) (
    input  logic  aclk,
    input  logic  aclken,
    input  logic  rst_n,

    input  logic  req,
    input  len_t  vec_len,
    input  user_t tag,
    output logic  ack,

    output logic  take,
    input  logic  a_valid,
    input  logic  b_valid,
    input  data_t a_data,
    input  data_t b_data,

    output data_t result,
    output user_t result_tag
);

    logic  cnt_load;
    logic  at_last;
    logic  pair_accept;
    logic  pair_last;
    user_t job_tag;

    logic  mul_valid;
    data_t mul_data;
    logic  mul_last;
    user_t mul_user;

    logic  acc_valid;
    data_t acc_data;
    logic  acc_last;
    user_t acc_user;

    job_control u_ctrl (
        .aclk        (aclk),
        .aclken      (aclken),
        .rst_n       (rst_n),
        .req         (req),
        .tag         (tag),
        .a_valid     (a_valid),
        .b_valid     (b_valid),
        .at_last     (at_last),
        .res_valid   (acc_valid),
        .res_last    (acc_last),
        .res_data    (acc_data),
        .res_user    (acc_user),
        .ack         (ack),
        .take        (take),
        .cnt_load    (cnt_load),
        .pair_accept (pair_accept),
        .pair_last   (pair_last),
        .job_tag     (job_tag),
        .result      (result),
        .result_tag  (result_tag)
    );

    element_counter u_cnt (
        .aclk    (aclk),
        .aclken  (aclken),
        .rst_n   (rst_n),
        .load    (cnt_load),
        .vec_len (vec_len),
        .step    (pair_accept),
        .at_last (at_last)
    );

    stream_multiplier #(
        .MUL_DELAY (MUL_DELAY)
    ) u_mul (
        .aclk      (aclk),
        .aclken    (aclken),
        .rst_n     (rst_n),
        .valid_in  (pair_accept),
        .a_data    (a_data),
        .b_data    (b_data),
        .last_in   (pair_last),
        .user_in   (job_tag),
        .valid_out (mul_valid),
        .data_out  (mul_data),
        .last_out  (mul_last),
        .user_out  (mul_user)
    );

    stream_accumulator #(
        .ACC_DELAY (ACC_DELAY)
    ) u_acc (
        .aclk      (aclk),
        .aclken    (aclken),
        .rst_n     (rst_n),
        .valid_in  (mul_valid),
        .data_in   (mul_data),
        .last_in   (mul_last),
        .user_in   (mul_user),
        .valid_out (acc_valid),
        .data_out  (acc_data),
        .last_out  (acc_last),
        .user_out  (acc_user)
    );

endmodule

/* source/dot_pkg.sv */
package dot_pkg;

    // operand, product and running sum, all modulo 2^16
    typedef logic [15:0] data_t;

    typedef logic [3:0]  user_t;  // job tag sideband
    typedef logic [7:0]  len_t;   // 0 means 256 elements

    typedef enum logic [1:0] {
        ST_IDLE,    // waiting for req
        ST_STREAM,  // taking operand pairs
        ST_DRAIN,   // last pair in flight
        ST_DONE     // result latched, ack high
    } ctrl_state_t;

endpackage

/* source/element_counter.sv */
`timescale 1ns/1ps

module element_counter
    import dot_pkg::*;
(
    input  logic aclk,
    input  logic aclken,
    input  logic rst_n,

    input  logic load,
    input  len_t vec_len,
    input  logic step,

    output logic at_last
);

    len_t remaining;  // elements left after the current one

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            remaining <= '0;
        end else if (aclken) begin
            if (load) begin
                remaining <= vec_len - len_t'(1);  // 0 wraps to 255
            end else if (step) begin
                remaining <= remaining - len_t'(1);
            end
        end
    end

    assign at_last = (remaining == '0);

endmodule

/* source/job_control.sv */
`timescale 1ns/1ps

module job_control
    import dot_pkg::*;
(
    input  logic  aclk,
    input  logic  aclken,
    input  logic  rst_n,

    input  logic  req,
    input  user_t tag,
    input  logic  a_valid,
    input  logic  b_valid,
    input  logic  at_last,

    input  logic  res_valid,
    input  logic  res_last,
    input  data_t res_data,
    input  user_t res_user,

    output logic  ack,
    output logic  take,
    output logic  cnt_load,
    output logic  pair_accept,
    output logic  pair_last,
    output user_t job_tag,
    output data_t result,
    output user_t result_tag
);

    ctrl_state_t state;

    assign take        = (state == ST_STREAM);
    assign ack         = (state == ST_DONE);
    assign cnt_load    = (state == ST_IDLE) && req;
    assign pair_accept = take && a_valid && b_valid;  // sinks also wait for aclken
    assign pair_last   = pair_accept && at_last;

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            state      <= ST_IDLE;
            result     <= '0;
            result_tag <= '0;
        end else if (aclken) begin
            case (state)
                ST_IDLE: begin
                    if (req) begin
                        state <= ST_STREAM;
                    end
                end
                ST_STREAM: begin
                    if (pair_last) begin
                        state <= ST_DRAIN;
                    end
                end
                ST_DRAIN: begin
                    if (res_valid && res_last) begin  // final sum of this job
                        state      <= ST_DONE;
                        result     <= res_data;
                        result_tag <= res_user;
                    end
                end
                ST_DONE: begin
                    if (!req) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (aclken && cnt_load) begin
            job_tag <= tag;  // rides along as user
        end
    end

endmodule

/* source/stream_accumulator.sv */
`timescale 1ns/1ps

module stream_accumulator
    import dot_pkg::*;
#(
    parameter int ACC_DELAY = 2
) (
    input  logic  aclk,
    input  logic  aclken,
    input  logic  rst_n,

    input  logic  valid_in,
    input  data_t data_in,
    input  logic  last_in,
    input  user_t user_in,

    output logic  valid_out,
    output data_t data_out,
    output logic  last_out,
    output user_t user_out
);

    logic  clear;
    logic  hold_valid;
    data_t hold_data;
    logic  hold_last;
    user_t hold_user;
    data_t held_sum;
    data_t sum_in;

    // set once a vector has ended, so the next input starts a new sum
    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            clear <= 1'b1;
        end else if (aclken && valid_in) begin
            clear <= last_in;
        end
    end

    assign held_sum = clear ? '0 : hold_data;
    assign sum_in   = valid_in ? data_in + held_sum : held_sum;  // sum rides through gaps

    delay_stream #(
        .N (1)
    ) u_sum_reg (
        .aclk      (aclk),
        .aclken    (aclken),
        .rst_n     (rst_n),
        .valid_in  (valid_in),
        .data_in   (sum_in),
        .last_in   (last_in),
        .user_in   (user_in),
        .valid_out (hold_valid),
        .data_out  (hold_data),
        .last_out  (hold_last),
        .user_out  (hold_user)
    );

    if (ACC_DELAY > 1) begin : g_tail
        delay_stream #(
            .N (ACC_DELAY - 1)
        ) u_tail (
            .aclk      (aclk),
            .aclken    (aclken),
            .rst_n     (rst_n),
            .valid_in  (hold_valid),
            .data_in   (hold_data),
            .last_in   (hold_last),
            .user_in   (hold_user),
            .valid_out (valid_out),
            .data_out  (data_out),
            .last_out  (last_out),
            .user_out  (user_out)
        );
    end else begin : g_bypass
        assign valid_out = hold_valid;
        assign data_out  = hold_data;
        assign last_out  = hold_last;
        assign user_out  = hold_user;
    end

endmodule

/* source/stream_multiplier.sv */
`timescale 1ns/1ps

module stream_multiplier
    import dot_pkg::*;
#(
    parameter int MUL_DELAY = 3
) (
    input  logic  aclk,
    input  logic  aclken,
    input  logic  rst_n,

    input  logic  valid_in,
    input  data_t a_data,
    input  data_t b_data,
    input  logic  last_in,
    input  user_t user_in,

    output logic  valid_out,
    output data_t data_out,
    output logic  last_out,
    output user_t user_out
);

    data_t product;

    // truncated to 16 bits, zero between pairs
    assign product = valid_in ? a_data * b_data : '0;

    delay_stream #(
        .N (MUL_DELAY)
    ) u_mul_pipe (
        .aclk      (aclk),
        .aclken    (aclken),
        .rst_n     (rst_n),
        .valid_in  (valid_in),
        .data_in   (product),
        .last_in   (last_in),
        .user_in   (user_in),
        .valid_out (valid_out),
        .data_out  (data_out),
        .last_out  (last_out),
        .user_out  (user_out)
    );

endmodule

/* src.f */
source/dot_pkg.sv
source/delay_stream.sv
source/stream_multiplier.sv
source/stream_accumulator.sv
source/element_counter.sv
source/job_control.sv
source/dot_engine.sv
tests/dot_engine_assertions.sv
tests/tb_dot_engine.sv

/* tests/dot_engine_assertions.sv */
`timescale 1ns/1ps

module dot_engine_assertions
    import dot_pkg::*;
(
    input logic  aclk,
    input logic  aclken,
    input logic  rst_n,
    input logic  req,
    input logic  ack,
    input logic  take,
    input data_t result
);

    ack_needs_req: assert property (@(posedge aclk) disable iff (!rst_n)
        $rose(ack) |-> req)
        else $error("ack rose without req");

    // a new job only opens on a request
    take_needs_req: assert property (@(posedge aclk) disable iff (!rst_n)
        $rose(take) |-> $past(req))
        else $error("take rose without a request");

    // result latched once, then frozen while the host reads it
    result_stable: assert property (@(posedge aclk) disable iff (!rst_n)
        ($past(ack) && ack) |-> $stable(result))
        else $error("result changed while ack was high");

    ack_release: assert property (@(posedge aclk) disable iff (!rst_n)
        (ack && !req && aclken) |=> !ack)
        else $error("ack held after req fell");

endmodule

bind job_control dot_engine_assertions u_handshake_checks (
    .aclk   (aclk),
    .aclken (aclken),
    .rst_n  (rst_n),
    .req    (req),
    .ack    (ack),
    .take   (take),
    .result (result)
);

/* tests/tb_dot_engine.sv */
`timescale 1ns/1ps

module tb_dot_engine
    import dot_pkg::*;
;
    localparam int CLK_PERIOD = 40;
    localparam int MUL_DELAY  = 3;  // dut runs at default latencies
    localparam int ACC_DELAY  = 2;
    localparam int ELEMS_TOTAL = 8 + 12 + (5 + 3 + 9) + (1 + 256) + 10 + 6;
    localparam int JOB_COUNT   = 9;
    // gaps cost about four cycles per pair, plus handshake and drain per job
    localparam int WATCHDOG_CYCLES = 4 * (4 * ELEMS_TOTAL + 40 * JOB_COUNT);

    logic  aclk;
    logic  aclken;
    logic  rst_n;
    logic  req;
    len_t  vec_len;
    user_t tag;
    logic  ack;
    logic  take;
    logic  a_valid;
    logic  b_valid;
    data_t a_data;
    data_t b_data;
    data_t result;
    user_t result_tag;

    logic [31:0] lfsr = 32'hb279;
    logic        stream_done;
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;

    dot_engine dut (
        .aclk       (aclk),
        .aclken     (aclken),
        .rst_n      (rst_n),
        .req        (req),
        .vec_len    (vec_len),
        .tag        (tag),
        .ack        (ack),
        .take       (take),
        .a_valid    (a_valid),
        .b_valid    (b_valid),
        .a_data     (a_data),
        .b_data     (b_data),
        .result     (result),
        .result_tag (result_tag)
    );

    initial begin
        aclk = 1'b0;
        forever #(CLK_PERIOD / 2) aclk = ~aclk;
    end

    // galois form, one step per bit handed out
    function automatic logic [31:0] lfsr_bits(input int count);
        logic [31:0] value;
        logic        bit_out;
        value = '0;
        for (int i = 0; i < count; i++) begin
            bit_out = lfsr[0];
            lfsr = lfsr >> 1;
            if (bit_out)
                lfsr = lfsr ^ 32'h80200003;
            value = {value[30:0], bit_out};
        end
        return value;
    endfunction

    task automatic check_data(input data_t got, input data_t want, input string what);
        checks++;
        if (got !== want) begin
            errors++;
            $display("[FAIL] t=%0t %s is %h, expected %h", $time, what, got, want);
        end
    endtask

    task automatic check_tag(input user_t got, input user_t want, input string what);
        checks++;
        if (got !== want) begin
            errors++;
            $display("[FAIL] t=%0t %s is %h, expected %h", $time, what, got, want);
        end
    endtask

    task automatic check_count(input int got, input int want, input string what);
        checks++;
        if (got != want) begin
            errors++;
            $display("[FAIL] t=%0t %s is %0d, expected %0d", $time, what, got, want);
        end
    endtask

    task automatic flag_error(input string what);
        errors++;
        $display("t=%0t %s", $time, what);
    endtask

    task automatic run_job(input len_t len, input user_t jtag, input bit gaps, input bit big,
                           input int hold);
        int    n;
        int    taken;
        int    edges;
        logic  en;
        logic  seen;
        data_t expect_sum;
        n = (len == 0) ? 256 : int'(len);
        taken = 0;
        expect_sum = '0;
        stream_done = 1'b0;
        @(posedge aclk);
        req     <= 1'b1;
        vec_len <= len;
        tag     <= jtag;
        while (taken < n) begin
            @(posedge aclk);
            a_valid <= gaps ? 1'(lfsr_bits(1)) : 1'b1;
            b_valid <= gaps ? 1'(lfsr_bits(1)) : 1'b1;
            a_data  <= big ? (16'hf000 | data_t'(lfsr_bits(12))) : data_t'(lfsr_bits(16));
            b_data  <= big ? (16'hf000 | data_t'(lfsr_bits(12))) : data_t'(lfsr_bits(16));
            @(negedge aclk);
            if (aclken && take && a_valid && b_valid) begin  // taken at the next edge
                expect_sum = expect_sum + data_t'(a_data * b_data);
                taken++;
            end
        end
        @(posedge aclk);  // last pair goes in here
        a_valid <= 1'b0;
        b_valid <= 1'b0;
        stream_done = 1'b1;
        edges = 0;
        seen = 1'b0;
        @(negedge aclk);
        while (!seen) begin
            if (take)
                flag_error("take stayed high after the last pair");
            en = aclken;
            seen = ack && aclken;  // next edge samples ack high
            @(posedge aclk);
            if (en)
                edges++;
            @(negedge aclk);
        end
        check_count(edges, MUL_DELAY + ACC_DELAY + 1, "enabled cycles to ack");
        check_data(result, expect_sum, "result");
        check_tag(result_tag, jtag, "result_tag");
        for (int i = 0; i < hold; i++) begin
            @(negedge aclk);
            if (!ack)
                flag_error("ack dropped while req was still high");
            check_data(result, expect_sum, "held result");
        end
        @(posedge aclk);
        req <= 1'b0;
        @(posedge aclk);
        @(negedge aclk);
        if (ack)
            flag_error("ack still high one cycle after req fell");
        repeat (2) begin
            @(negedge aclk);
            if (take)
                flag_error("take rose while req was low");
            check_data(result, expect_sum, "result between jobs");
        end
    endtask

    // freezes the engine once while streaming and once while draining
    task automatic stall_enable();
        repeat (4) @(posedge aclk);
        aclken <= 1'b0;
        repeat (5) @(posedge aclk);
        aclken <= 1'b1;
        wait (stream_done);
        @(posedge aclk);
        aclken <= 1'b0;
        repeat (5) @(posedge aclk);
        aclken <= 1'b1;
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests++;
        if (errors == errors_before)
            $display("test %s: ok", name);
        else
            $display("test %s: %0d errors", name, errors - errors_before);
    endtask

    task automatic test_single();
        int start = errors;
        run_job(8'd8, 4'h3, 1'b0, 1'b0, 0);
        report_test("single job", start);
    endtask

    task automatic test_gaps();
        int start = errors;
        run_job(8'd12, 4'h5, 1'b1, 1'b0, 0);
        report_test("stream gaps", start);
    endtask

    task automatic test_back_to_back();
        int start = errors;
        run_job(8'd5, 4'h9, 1'b0, 1'b0, 0);
        run_job(8'd3, 4'ha, 1'b1, 1'b0, 0);
        run_job(8'd9, 4'h1, 1'b0, 1'b1, 0);
        report_test("back to back", start);
    endtask

    task automatic test_edge_lengths();
        int start = errors;
        run_job(8'd1, 4'h7, 1'b0, 1'b1, 0);
        run_job(8'd0, 4'hc, 1'b0, 1'b1, 0);  // 256 elements
        report_test("edge lengths", start);
    endtask

    task automatic test_stall();
        int start = errors;
        fork
            run_job(8'd10, 4'h2, 1'b0, 1'b0, 0);
            stall_enable();
        join
        report_test("clock enable stall", start);
    endtask

    task automatic test_handshake_hold();
        int start = errors;
        run_job(8'd6, 4'he, 1'b0, 1'b0, 5);
        report_test("handshake hold", start);
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, the DUT hung", WATCHDOG_CYCLES);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        aclken      = 1'b1;
        rst_n       = 1'b0;
        req         = 1'b0;
        vec_len     = '0;
        tag         = '0;
        a_valid     = 1'b0;
        b_valid     = 1'b0;
        a_data      = '0;
        b_data      = '0;
        stream_done = 1'b0;
        repeat (4) @(posedge aclk);
        rst_n <= 1'b1;
        @(negedge aclk);
        if (take || ack)
            flag_error("take or ack high after reset");
        check_data(result, '0, "result after reset");
        test_single();
        test_gaps();
        test_back_to_back();
        test_edge_lengths();
        test_stall();
        test_handshake_hold();
        $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
